//--- include/fetch_params.svh
/*
	Fetch stage parameters
	Address queue geometry, instruction RAM size and start address
*/
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Fetch address queue
`define FETCH_QUEUE_DEPTH	8
`define FETCH_QUEUE_DEPTH_N	3	// Pointer width

// Word-indexed instruction RAM
`define INST_MEM_WORDS		256
`define INST_MEM_ADDR_W		8

// First fetch address after reset
`define RESET_PC			32'h0000_0000

`endif

//--- logic/fetch.sv
/*
	Instruction fetch unit
	PC sequencer, fetch address queue and the register toward decode
*/
`timescale 1ns/10ps
`default_nettype none
`include "fetch_params.svh"

module fetch
	import fetch_pkg::*;
(
	input wire				iCLOCK,
	input wire				inRESET,
	input wire psr_u		psr,
	input wire				exception_event,
	input wire				exception_addr_set,
	input wire [31:0]		exception_addr,
	output fetch_req_t		req,
	input wire mem_resp_t	resp,
	input wire				fetch_lock,
	output logic			mem_lock,
	input wire				fetch_stop,
	input wire				next_lock,
	output fetch_out_t		out
);

	localparam logic [1:0] ST_RESET = 2'd0;
	localparam logic [1:0] ST_FETCH = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;	// Flushed, waiting for a new address

	logic [1:0]		state;
	logic [31:0]	pc;
	logic			accept;
	queue_entry_t	q_wr_entry;
	queue_entry_t	q_head;
	logic			q_full;
	logic			q_empty;
	logic			q_pop;

	logic			out_valid;
	logic [13:0]	out_flags;
	logic			out_paging_ena;
	logic			out_kernel_access;
	logic [31:0]	out_inst;
	logic [31:0]	out_pc;

	// Any stall condition drops the request in the same cycle
	assign accept = (state == ST_FETCH) && !exception_event && !q_full &&
		!fetch_lock && !fetch_stop;

	assign req = '{req: accept, mmumod: psr.fields.mmumod, addr: pc};
	assign mem_lock = next_lock;	// Memory holds its answer while decode stalls

	// Attributes sampled with the address
	assign q_wr_entry = '{
		kernel_access: (psr.fields.priv == 2'b00),
		paging_ena: (psr.fields.mmumod != 2'b00),
		addr: pc
	};
	assign q_pop = resp.valid && !q_empty;

	sync_fifo #(
		.WIDTH($bits(queue_entry_t)),
		.DEPTH(`FETCH_QUEUE_DEPTH),
		.DEPTH_N(`FETCH_QUEUE_DEPTH_N)
	) u_addr_queue (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(exception_event),
		.wr_en(accept),
		.wr_data(q_wr_entry),
		.full(q_full),
		.rd_en(q_pop),
		.rd_data(q_head),
		.empty(q_empty),
		.count()
	);

	// PC sequencer
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_RESET;
			pc <= `RESET_PC;
		end else if (exception_addr_set) begin	// Redirect
			state <= ST_FETCH;
			pc <= {exception_addr[31:1], 1'b0};
		end else if (exception_event) begin
			state <= ST_WAIT;
		end else begin
			case (state)
				ST_RESET: begin
					state <= ST_FETCH;
					pc <= `RESET_PC;
				end
				ST_FETCH: begin
					if (accept) begin
						pc <= pc + 32'd4;
					end
				end
				ST_WAIT: begin
					// Only an address set leaves this state
				end
				default: begin
					state <= ST_RESET;
				end
			endcase
		end
	end

	// Valid bit of the decode-side register
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_valid <= 1'b0;
		end else if (exception_event) begin
			out_valid <= 1'b0;
		end else if (!next_lock) begin
			out_valid <= resp.valid;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (!next_lock) begin
			out_flags <= resp.mmu_flags;
			out_inst <= resp.inst;
			out_paging_ena <= q_head.paging_ena;
			out_kernel_access <= q_head.kernel_access;
			out_pc <= q_head.addr + 32'd4;	// Next PC after this word
		end
	end

	assign out = '{
		valid: out_valid,
		mmu_flags: out_flags,
		paging_ena: out_paging_ena,
		kernel_access: out_kernel_access,
		inst: out_inst,
		pc: out_pc
	};

endmodule

`default_nettype wire

//--- logic/fetch_pkg.sv
/*
	Fetch stage types
	Status word views and the request, response, queue and decode-side words
*/
`default_nettype none

package fetch_pkg;

	// Status word fields used by fetch
	typedef struct packed {
		logic [24:0]	reserved_hi;
		logic [1:0]		priv;		// Zero means kernel
		logic [2:0]		reserved_lo;
		logic [1:0]		mmumod;		// Nonzero enables paging
	} psr_fields_t;

	typedef union packed {
		logic [31:0]	raw;
		psr_fields_t	fields;
	} psr_u;

	typedef struct packed {
		logic			req;
		logic [1:0]		mmumod;
		logic [31:0]	addr;
	} fetch_req_t;

	// Flag bit 0 out of range, bit 1 misaligned
	typedef struct packed {
		logic			valid;
		logic [13:0]	mmu_flags;
		logic [31:0]	inst;
	} mem_resp_t;

	typedef struct packed {
		logic			kernel_access;
		logic			paging_ena;
		logic [31:0]	addr;
	} queue_entry_t;

	typedef struct packed {
		logic			valid;
		logic [13:0]	mmu_flags;
		logic			paging_ena;
		logic			kernel_access;
		logic [31:0]	inst;
		logic [31:0]	pc;
	} fetch_out_t;

endpackage

`default_nettype wire

//--- logic/fetch_top.sv
/*
	Fetch stage top level
	Fetch unit beside its instruction memory
*/
`timescale 1ns/10ps
`default_nettype none
`include "fetch_params.svh"

module fetch_top
	import fetch_pkg::*;
(
	input wire								iCLOCK,
	input wire								inRESET,
	input wire psr_u						psr,
	input wire								exception_event,
	input wire								exception_addr_set,
	input wire [31:0]						exception_addr,
	input wire								load_en,
	input wire [`INST_MEM_ADDR_W-1:0]		load_addr,
	input wire [31:0]						load_data,
	input wire								fetch_stop,
	input wire								next_lock,
	output fetch_out_t						out
);

	fetch_req_t	req;
	mem_resp_t	resp;
	logic		fetch_lock;
	logic		mem_lock;

	fetch u_fetch (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.psr(psr),
		.exception_event(exception_event),
		.exception_addr_set(exception_addr_set),
		.exception_addr(exception_addr),
		.req(req),
		.resp(resp),
		.fetch_lock(fetch_lock),
		.mem_lock(mem_lock),
		.fetch_stop(fetch_stop),
		.next_lock(next_lock),
		.out(out)
	);

	// Exception also drops the read in flight
	inst_mem u_inst_mem (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(exception_event),
		.req(req),
		.resp(resp),
		.lock(mem_lock),
		.fetch_lock(fetch_lock),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data)
	);

endmodule

`default_nettype wire

//--- logic/inst_mem.sv
/*
	Instruction memory
	Word RAM with a load port, registered reads, a skid slot for lock
	and out-of-range / misaligned fault flags
*/
`timescale 1ns/10ps
`default_nettype none
`include "fetch_params.svh"

module inst_mem
	import fetch_pkg::*;
(
	input wire								iCLOCK,
	input wire								inRESET,
	input wire								flush,
	input wire fetch_req_t					req,
	output mem_resp_t						resp,
	input wire								lock,
	output logic							fetch_lock,
	input wire								load_en,
	input wire [`INST_MEM_ADDR_W-1:0]		load_addr,
	input wire [31:0]						load_data
);

	logic [31:0]					ram [`INST_MEM_WORDS];
	logic [`INST_MEM_ADDR_W-1:0]	rd_idx;
	logic							out_of_range;
	logic							misaligned;
	logic [13:0]					rd_flags;

	logic							pipe_valid;
	logic [13:0]					pipe_flags;
	logic [31:0]					pipe_raw;
	logic [31:0]					pipe_inst;
	logic							skid_valid;
	logic [13:0]					skid_flags;
	logic [31:0]					skid_inst;
	logic							pipe_to_skid;

	assign rd_idx = req.addr[`INST_MEM_ADDR_W+1:2];
	assign out_of_range = (req.addr[31:2] >= 30'(`INST_MEM_WORDS));
	assign misaligned = req.addr[1];
	assign rd_flags = {12'h000, misaligned, out_of_range};

	// Faulting range reads return zero
	assign pipe_inst = pipe_flags[0] ? 32'h0 : pipe_raw;

	// Locked answer would be overwritten by the new read
	assign pipe_to_skid = pipe_valid && !skid_valid && lock && req.req;

	// Skid slot is the older one and goes first
	assign resp.valid = (skid_valid || pipe_valid) && !lock;
	assign resp.mmu_flags = skid_valid ? skid_flags : pipe_flags;
	assign resp.inst = skid_valid ? skid_inst : pipe_inst;

	assign fetch_lock = skid_valid || load_en;	// Stop fetch while loading too

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pipe_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else if (flush) begin
			pipe_valid <= 1'b0;
			skid_valid <= 1'b0;
		end else begin
			if (req.req) begin
				pipe_valid <= 1'b1;
			end else if (!lock && !skid_valid) begin
				pipe_valid <= 1'b0;		// Delivered
			end
			if (pipe_to_skid) begin
				skid_valid <= 1'b1;
			end else if (!lock) begin
				skid_valid <= 1'b0;
			end
		end
	end

	// RAM write and read ports
	always_ff @(posedge iCLOCK) begin
		if (load_en) begin
			ram[load_addr] <= load_data;
		end
		if (req.req) begin
			pipe_raw <= ram[rd_idx];
			pipe_flags <= rd_flags;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (pipe_to_skid) begin
			skid_flags <= pipe_flags;
			skid_inst <= pipe_inst;
		end
	end

endmodule

`default_nettype wire

//--- logic/sync_fifo.sv
/*
	Synchronous FIFO
	Circular buffer with show-ahead read and a one-cycle flush
*/
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 34,
	parameter int DEPTH = 8,
	parameter int DEPTH_N = 3
)(
	input wire					iCLOCK,
	input wire					inRESET,
	input wire					flush,
	input wire					wr_en,
	input wire [WIDTH-1:0]		wr_data,
	output logic				full,
	input wire					rd_en,
	output logic [WIDTH-1:0]	rd_data,
	output logic				empty,
	output logic [DEPTH_N:0]	count
);

	localparam logic [DEPTH_N:0] FULL_COUNT = (DEPTH_N + 1)'(DEPTH);
	localparam logic [DEPTH_N-1:0] LAST_IDX = DEPTH_N'(DEPTH - 1);

	logic [WIDTH-1:0]	mem [DEPTH];
	logic [DEPTH_N-1:0]	wr_idx;
	logic [DEPTH_N-1:0]	rd_idx;
	logic [DEPTH_N:0]	fill;
	logic				do_wr;
	logic				do_rd;

	assign full = (fill == FULL_COUNT);
	assign empty = (fill == '0);
	assign count = fill;
	assign do_wr = wr_en && !full;		// Writes to a full buffer are dropped
	assign do_rd = rd_en && !empty;
	assign rd_data = mem[rd_idx];		// Show-ahead head word

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_idx <= '0;
			rd_idx <= '0;
			fill <= '0;
		end else if (flush) begin
			wr_idx <= '0;
			rd_idx <= '0;
			fill <= '0;
		end else begin
			if (do_wr) begin
				wr_idx <= (wr_idx == LAST_IDX) ? '0 : wr_idx + 1'b1;
			end
			if (do_rd) begin
				rd_idx <= (rd_idx == LAST_IDX) ? '0 : rd_idx + 1'b1;
			end
			// Simultaneous push and pop keeps the level
			if (do_wr && !do_rd) begin
				fill <= fill + 1'b1;
			end else if (!do_wr && do_rd) begin
				fill <= fill - 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (do_wr) begin
			mem[wr_idx] <= wr_data;
		end
	end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
logic/fetch_pkg.sv
logic/sync_fifo.sv
logic/fetch.sv
logic/inst_mem.sv
logic/fetch_top.sv
verif/fetch_tb.sv

//--- verif/fetch_tb.sv
/*
	Fetch stage testbench
	Loads a random program, streams fetches under lock and stop
	and checks each decode-side word against a reference model
*/
`timescale 1ns/10ps
`default_nettype none
`include "fetch_params.svh"

module fetch_tb
	import fetch_pkg::*;
;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int N_SEQ = 40;
	localparam int N_LOCK = 60;
	localparam int N_STOP = 60;
	localparam int N_MIXED = 60;
	localparam int N_REDIRECT = 4 * 20;
	localparam int N_PSR = 4 * 20;
	localparam int N_FAULT = 8 + 6 + 6;
	localparam int TOTAL_ITEMS = N_SEQ + N_LOCK + N_STOP + N_MIXED + N_REDIRECT + N_PSR + N_FAULT;
	localparam int TEST_CYCLES = RESET_CYCLES + `INST_MEM_WORDS + 8 * TOTAL_ITEMS;

	logic							iCLOCK;
	logic							inRESET;
	psr_u							psr;
	logic							exception_event;
	logic							exception_addr_set;
	logic [31:0]					exception_addr;
	logic							load_en;
	logic [`INST_MEM_ADDR_W-1:0]	load_addr;
	logic [31:0]					load_data;
	logic							fetch_stop;
	logic							next_lock;
	fetch_out_t						out;

	logic [31:0]	prog [`INST_MEM_WORDS];	// Copy of the loaded program
	integer			seed = 6294;
	int				errors = 0;
	int				checked = 0;
	int				idle_run = 0;
	logic			stream_live = 1'b0;		// Low between flush and new address
	logic [31:0]	exp_addr = '0;
	logic			hold_pending = 1'b0;
	fetch_out_t		held_out;
	logic			lock_rand = 1'b0;
	logic			stop_rand = 1'b0;
	logic			stop_hold = 1'b1;

	fetch_top UUT (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.psr(psr),
		.exception_event(exception_event),
		.exception_addr_set(exception_addr_set),
		.exception_addr(exception_addr),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data),
		.fetch_stop(fetch_stop),
		.next_lock(next_lock),
		.out(out)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	// Reference for one fetched word
	function automatic fetch_out_t expected_out(input logic [31:0] addr, input psr_u status);
		fetch_out_t	e;
		logic		oor;
		oor = (addr[31:2] >= `INST_MEM_WORDS);
		e = '0;
		e.valid = 1'b1;
		e.mmu_flags[0] = oor;
		e.mmu_flags[1] = addr[1];	// Misaligned
		e.inst = oor ? 32'h0 : prog[addr[`INST_MEM_ADDR_W+1:2]];
		e.paging_ena = (status.fields.mmumod != 2'b00);
		e.kernel_access = (status.fields.priv == 2'b00);
		e.pc = addr + 32'd4;
		return e;
	endfunction

	task automatic report_mismatch(input string field, input logic [31:0] got,
		input logic [31:0] want, input logic [31:0] addr);
		errors++;
		$display("ERROR %0t: %s is %h, expected %h (fetch address %h)",
			$time, field, got, want, addr);
	endtask

	task automatic compare_output(input logic [31:0] addr);
		fetch_out_t e;
		e = expected_out(addr, psr);
		assert (out.pc == e.pc) else report_mismatch("pc", out.pc, e.pc, addr);
		assert (out.inst == e.inst) else report_mismatch("inst", out.inst, e.inst, addr);
		assert (out.mmu_flags == e.mmu_flags)
			else report_mismatch("mmu_flags", 32'(out.mmu_flags), 32'(e.mmu_flags), addr);
		assert (out.paging_ena == e.paging_ena)
			else report_mismatch("paging_ena", 32'(out.paging_ena), 32'(e.paging_ena), addr);
		assert (out.kernel_access == e.kernel_access)
			else report_mismatch("kernel_access", 32'(out.kernel_access),
				32'(e.kernel_access), addr);
	endtask

	// Checker samples mid-cycle
	always @(negedge iCLOCK) begin
		if (inRESET) begin
			if (out.valid) begin
				idle_run = 0;
				assert (stream_live) else begin
					errors++;
					$display("ERROR %0t: output valid after an exception flush", $time);
				end
				if (stream_live && !next_lock) begin	// Taken by decode at next edge
					compare_output(exp_addr);
					exp_addr = exp_addr + 32'd4;
					checked++;
				end
			end else begin
				idle_run++;
			end
			if (hold_pending) begin
				assert (out == held_out) else begin
					errors++;
					$display("ERROR %0t: output changed while next_lock was high", $time);
				end
			end
			hold_pending = out.valid && next_lock && !exception_event;
			held_out = out;
			if (exception_event) begin
				stream_live = 1'b0;
			end
			if (exception_addr_set) begin
				exp_addr = {exception_addr[31:1], 1'b0};
				stream_live = 1'b1;
			end
		end
	end

	// One clock of lock / stop stimulus
	task automatic step_cycle();
		logic [31:0] rnd;
		@(posedge iCLOCK);
		rnd = $random(seed);
		next_lock <= lock_rand && rnd[0];
		fetch_stop <= stop_hold || (stop_rand && rnd[1] && rnd[2]);	// About one in four
	endtask

	task automatic run_items(input int n);
		int target;
		target = checked + n;
		while (checked < target) begin
			step_cycle();
		end
	endtask

	task automatic load_program();
		logic [31:0] rnd;
		for (int i = 0; i < `INST_MEM_WORDS; i++) begin
			@(posedge iCLOCK);
			rnd = $random(seed);
			prog[i] = rnd;
			load_en <= 1'b1;
			load_addr <= i[`INST_MEM_ADDR_W-1:0];
			load_data <= rnd;
		end
		@(posedge iCLOCK);
		load_en <= 1'b0;
	endtask

	task automatic redirect_to(input logic [31:0] target);
		@(posedge iCLOCK);
		exception_event <= 1'b1;
		@(posedge iCLOCK);
		exception_event <= 1'b0;
		exception_addr_set <= 1'b1;
		exception_addr <= target;
		@(posedge iCLOCK);
		exception_addr_set <= 1'b0;
	endtask

	// Stop fetch and wait until nothing is left in flight
	task automatic drain_pipeline();
		stop_hold = 1'b1;
		lock_rand = 1'b0;
		step_cycle();
		idle_run = 0;
		while (idle_run < 4) begin
			step_cycle();
		end
	endtask

	task automatic set_mode(input logic lock_on, input logic stop_on);
		stop_hold = 1'b0;
		lock_rand = lock_on;
		stop_rand = stop_on;
	endtask

	initial begin
		inRESET = 1'b0;
		psr = '0;
		exception_event = 1'b0;
		exception_addr_set = 1'b0;
		exception_addr = '0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		fetch_stop = 1'b1;
		next_lock = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		inRESET <= 1'b1;
		load_program();
		redirect_to(`RESET_PC);

		set_mode(1'b0, 1'b0);	// Plain sequential stream
		run_items(N_SEQ);
		set_mode(1'b1, 1'b0);
		run_items(N_LOCK);
		set_mode(1'b0, 1'b1);
		run_items(N_STOP);
		set_mode(1'b1, 1'b1);
		run_items(N_MIXED);

		for (int i = 0; i < 4; i++) begin
			redirect_to($random(seed) & 32'h0000_03FF);	// Random bit 0 is dropped by fetch
			run_items(N_REDIRECT / 4);
		end

		for (int i = 0; i < 4; i++) begin
			drain_pipeline();
			@(posedge iCLOCK);
			psr <= $random(seed);
			set_mode(1'b1, 1'b1);
			run_items(N_PSR / 4);
		end

		redirect_to(32'h0000_03F8);	// Runs off the end of the RAM
		run_items(8);
		redirect_to(32'h0000_0803);	// Out of range and misaligned
		run_items(6);
		redirect_to(32'h0000_0106);	// Misaligned only
		run_items(6);

		drain_pipeline();
		$display("Checked %0d outputs, %0d errors", checked, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(TEST_CYCLES * CLK_PERIOD * 4);
		$display("Timeout: the fetch stream stopped before all tests finished (%0d errors)",
			errors);
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
